// ==== Bender.yml ====
package:
  name: line_fetch

sources:
  # design
  - files:
      - source/line_fetch_pkg.sv
      - source/request_sequencer.sv
      - source/wait_state_memory.sv
      - source/line_assembler.sv
      - source/line_fetch_top.sv

  # testbench and bound checker
  - target: simulation
    files:
      - dv/line_fetch_chk.sv
      - dv/tb_line_fetch.sv

// ==== dv/line_fetch_chk.sv ====
module line_fetch_chk
	import line_fetch_pkg::*;
(
	input logic       clock,
	input logic       reset,
	input logic       cmd_valid,
	input logic       cmd_write,
	input logic       cmd_busy,
	input logic       mem_enable,
	input logic       mem_ready,
	input mem_state_t memory_state,
	input logic       read_valid,
	input logic       line_done,
	input addr_t      line_address
);

	timeunit 1ns;
	timeprecision 1ps;

	int violations = 0;

	//////////////////////////////
	// memory protocol
	//////////////////////////////

	a_enable_ready: assert property (@(posedge clock) disable iff (reset)
		mem_enable |-> mem_ready && memory_state == mem_idle)
		else begin
			$error("mem_enable given while the memory is not ready");
			violations++;
		end

	a_burst_length: assert property (@(posedge clock) disable iff (reset)
		$rose(read_valid) |-> read_valid [*16] ##1 !read_valid)
		else begin
			$error("read burst is not 16 consecutive words");
			violations++;
		end

	//////////////////////////////
	// line output
	//////////////////////////////

	a_done_pulse: assert property (@(posedge clock) disable iff (reset)
		line_done |=> !line_done)
		else begin
			$error("line_done held for more than one cycle");
			violations++;
		end

	a_line_aligned: assert property (@(posedge clock) disable iff (reset)
		line_address[5:0] == 6'b0)
		else begin
			$error("line_address is not aligned to a line");
			violations++;
		end

	//////////////////////////////
	// latency from idle
	//////////////////////////////

	// sampled values, so line_done shows one edge after it is set
	a_read_latency: assert property (@(posedge clock) disable iff (reset)
		cmd_valid && !cmd_busy && !cmd_write |-> ##1 !line_done [*20] ##1 line_done)
		else begin
			$error("read from idle did not finish in 20 cycles");
			violations++;
		end

	a_write_latency: assert property (@(posedge clock) disable iff (reset)
		cmd_valid && !cmd_busy && cmd_write |-> ##1 cmd_busy [*5] ##1 !cmd_busy)
		else begin
			$error("write from idle did not clear cmd_busy after 5 cycles");
			violations++;
		end

endmodule

bind line_fetch_top line_fetch_chk chk (
	.clock        (clock),
	.reset        (reset),
	.cmd_valid    (cmd_valid),
	.cmd_write    (cmd_write),
	.cmd_busy     (cmd_busy),
	.mem_enable   (mem_enable),
	.mem_ready    (mem_ready),
	.memory_state (u_memory.state),
	.read_valid   (read_valid),
	.line_done    (line_done),
	.line_address (line_address)
);

// ==== dv/tb_line_fetch.sv ====
module tb_line_fetch
	import line_fetch_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	logic  clock;
	logic  reset;
	logic  cmd_valid;
	logic  cmd_write;
	addr_t cmd_address;
	word_t cmd_data;
	logic  cmd_busy;
	logic  line_done;
	addr_t line_address;
	line_t line_data;

	word_t  ref_mem [MEM_WORDS];   // reference copy of the memory words
	integer seed;
	int     cycle_count = 0;
	int     fail_count;
	int     fails_at_start;
	int     tests_passed;
	int     tests_failed;

	line_fetch_top uut (
		.clock        (clock),
		.reset        (reset),
		.cmd_valid    (cmd_valid),
		.cmd_write    (cmd_write),
		.cmd_address  (cmd_address),
		.cmd_data     (cmd_data),
		.cmd_busy     (cmd_busy),
		.line_done    (line_done),
		.line_address (line_address),
		.line_data    (line_data)
	);

	//////////////////////////////
	// clock and watchdog
	//////////////////////////////

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
	end

	initial begin
		wait (cycle_count >= 8000);   // full run is a few thousand cycles
		$display("timeout: line_done never arrived");
		$display("Simulation failed");
		$finish;
	end

	//////////////////////////////
	// command tasks
	//////////////////////////////

	// called on a falling edge, returns on the falling edge after the command edge
	task automatic issue_command(input logic write, input addr_t address, input word_t data);
		while (cmd_busy) begin
			@(negedge clock);
		end
		cmd_valid   = 1'b1;
		cmd_write   = write;
		cmd_address = address;
		cmd_data    = data;
		@(negedge clock);
		cmd_valid = 1'b0;
	endtask

	task automatic write_word(input addr_t address, input word_t data);
		int cycles;
		issue_command(1'b1, address, data);
		ref_mem[address / 4] = data;
		cycles = 0;
		while (cmd_busy) begin
			@(negedge clock);
			cycles++;
		end
		assert (cycles == 5) else begin
			$display("FAIL %0t: write at %h cleared busy after %0d cycles, expected 5",
				$time, address, cycles);
			fail_count++;
		end
	endtask

	task automatic read_line(input addr_t address);
		int    cycles;
		int    base_word;
		addr_t expected_address;
		line_t expected_line;
		base_word        = (address / (LINE_WORDS * 4)) * LINE_WORDS;  // 64-byte lines
		expected_address = addr_t'(base_word * 4);
		for (int i = 0; i < LINE_WORDS; i++) begin
			expected_line[i] = ref_mem[base_word + i];
		end
		issue_command(1'b0, address, '0);
		cycles = 0;
		while (!line_done) begin
			@(negedge clock);
			cycles++;
		end
		assert (line_address == expected_address && line_data == expected_line) else begin
			$display("FAIL %0t: read %h expected line %h data %h, got line %h data %h",
				$time, address, expected_address, expected_line, line_address, line_data);
			fail_count++;
		end
		assert (cycles == 20) else begin
			$display("FAIL %0t: read %h took %0d cycles, expected 20", $time, address, cycles);
			fail_count++;
		end
	endtask

	task automatic end_test(input string name);
		if (fail_count == fails_at_start) begin
			tests_passed++;
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d mismatches", name, fail_count - fails_at_start);
		end
		fails_at_start = fail_count;
	endtask

	//////////////////////////////
	// stimulus
	//////////////////////////////

	initial begin
		addr_t address;
		word_t data;
		seed           = 60557;
		reset          = 1'b1;
		cmd_valid      = 1'b0;
		cmd_write      = 1'b0;
		cmd_address    = '0;
		cmd_data       = '0;
		fail_count     = 0;
		fails_at_start = 0;
		tests_passed   = 0;
		tests_failed   = 0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			ref_mem[i] = '0;
		end
		repeat (4) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);

		read_line(12'h000);
		read_line(12'h040);
		read_line(12'h7c0);
		read_line(12'hfc0);
		end_test("reads after reset");

		for (int i = 0; i < LINE_WORDS; i++) begin
			write_word(addr_t'(12'h300 + 4 * i), word_t'(32'h1234_0001 + 32'h0101 * i));
		end
		read_line(12'h300);
		end_test("write line then read");

		read_line(12'h30c);   // all fall inside the line at 0x300
		read_line(12'h33f);
		read_line(12'h301);
		end_test("unaligned read");

		for (int i = 0; i < 12; i++) begin
			address = addr_t'(12'h800 + 20 * i);
			write_word(address, word_t'($random(seed)));
			write_word(address + 12'h4, word_t'($random(seed)));
			read_line(address + 12'h2);
		end
		end_test("back-to-back mixed");

		for (int i = 0; i < 150; i++) begin
			address = addr_t'($random(seed));
			data    = word_t'($random(seed));
			if ($random(seed) & 1) begin
				write_word(address, data);
			end else begin
				read_line(address);
			end
		end
		end_test("random commands");

		repeat (5) @(negedge clock);   // let everything go idle first
		read_line(12'h3a0);
		repeat (3) @(negedge clock);
		write_word(12'h3a4, 32'hc0ff_ee01);
		end_test("latency from idle");

		repeat (2) @(negedge clock);   // last write latency property ends one edge later
		fail_count = fail_count + uut.chk.violations;
		$display("tests passed: %0d, tests failed: %0d, assertion failures: %0d",
			tests_passed, tests_failed, uut.chk.violations);
		if (fail_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== source/line_assembler.sv ====
module line_assembler
	import line_fetch_pkg::*;
(
	input  logic  clock,
	input  logic  reset,
	input  logic  mem_enable,
	input  logic  mem_read,
	input  addr_t mem_address,
	input  logic  read_valid,
	input  word_t read_data,
	output logic  line_done,
	output addr_t line_address,
	output line_t line_data
);

	addr_t       base_address;  // line under way
	line_t       gather;
	word_index_t word_count;

	//////////////////////////////
	// gather
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (mem_enable && mem_read) begin
			base_address <= line_base(mem_address);
		end
		if (read_valid) begin
			gather[word_count] <= read_data;
		end
	end

	//////////////////////////////
	// publish
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			word_count   <= '0;
			line_done    <= 1'b0;
			line_address <= '0;
			line_data    <= '0;
		end else begin
			line_done <= 1'b0;
			if (read_valid) begin
				word_count <= word_count + 1'b1;  // wraps back to 0 after the last word
				if (word_count == word_index_t'(LINE_WORDS - 1)) begin
					line_done    <= 1'b1;
					line_address <= base_address;
					line_data    <= {read_data, gather[LINE_WORDS-2:0]};
				end
			end
		end
	end

endmodule

// ==== source/line_fetch_pkg.sv ====
package line_fetch_pkg;

	//////////////////////////////
	// sizes
	//////////////////////////////

	localparam int ADDR_BITS   = 12;   // byte address
	localparam int WORD_BITS   = 32;
	localparam int MEM_WORDS   = 1024;
	localparam int LINE_WORDS  = 16;
	localparam int WAIT_STATES = 2;    // extra cycles before an access takes effect

	localparam int BYTE_OFFSET_BITS = $clog2(WORD_BITS / 8);
	localparam int MEM_INDEX_BITS   = $clog2(MEM_WORDS);
	localparam int WORD_INDEX_BITS  = $clog2(LINE_WORDS);
	localparam int LINE_BYTES       = LINE_WORDS * WORD_BITS / 8;
	localparam int WAIT_COUNT_BITS  = $clog2(WAIT_STATES + 1);

	//////////////////////////////
	// types
	//////////////////////////////

	typedef logic [ADDR_BITS-1:0]       addr_t;
	typedef logic [WORD_BITS-1:0]       word_t;
	typedef logic [WORD_INDEX_BITS-1:0] word_index_t;
	typedef logic [LINE_WORDS-1:0][WORD_BITS-1:0] line_t;  // word 0 in the low bits

	typedef enum logic [1:0] {
		mem_idle,
		mem_wait,
		mem_burst
	} mem_state_t;

	// aligned base of the line that holds a byte address
	function automatic addr_t line_base(input addr_t address);
		return address & ~addr_t'(LINE_BYTES - 1);
	endfunction

endpackage

// ==== source/line_fetch_top.sv ====
module line_fetch_top
	import line_fetch_pkg::*;
(
	input  logic  clock,
	input  logic  reset,
	input  logic  cmd_valid,
	input  logic  cmd_write,
	input  addr_t cmd_address,
	input  word_t cmd_data,
	output logic  cmd_busy,
	output logic  line_done,
	output addr_t line_address,
	output line_t line_data
);

	logic  mem_enable;
	logic  mem_read;
	logic  mem_write;
	addr_t mem_address;
	word_t mem_write_data;
	logic  mem_ready;
	logic  read_valid;
	word_t read_data;

	//////////////////////////////
	// producer, memory, consumer
	//////////////////////////////

	request_sequencer u_sequencer (
		.clock          (clock),
		.reset          (reset),
		.cmd_valid      (cmd_valid),
		.cmd_write      (cmd_write),
		.cmd_address    (cmd_address),
		.cmd_data       (cmd_data),
		.mem_ready      (mem_ready),
		.mem_enable     (mem_enable),
		.mem_read       (mem_read),
		.mem_write      (mem_write),
		.mem_address    (mem_address),
		.mem_write_data (mem_write_data),
		.cmd_busy       (cmd_busy)
	);

	wait_state_memory u_memory (
		.clock          (clock),
		.reset          (reset),
		.mem_enable     (mem_enable),
		.mem_read       (mem_read),
		.mem_write      (mem_write),
		.mem_address    (mem_address),
		.mem_write_data (mem_write_data),
		.mem_ready      (mem_ready),
		.read_valid     (read_valid),
		.read_data      (read_data)
	);

	line_assembler u_assembler (
		.clock        (clock),
		.reset        (reset),
		.mem_enable   (mem_enable),   // snooped for the line address
		.mem_read     (mem_read),
		.mem_address  (mem_address),
		.read_valid   (read_valid),
		.read_data    (read_data),
		.line_done    (line_done),
		.line_address (line_address),
		.line_data    (line_data)
	);

endmodule

// ==== source/request_sequencer.sv ====
module request_sequencer
	import line_fetch_pkg::*;
(
	input  logic  clock,
	input  logic  reset,
	input  logic  cmd_valid,
	input  logic  cmd_write,
	input  addr_t cmd_address,
	input  word_t cmd_data,
	input  logic  mem_ready,
	output logic  mem_enable,
	output logic  mem_read,
	output logic  mem_write,
	output addr_t mem_address,
	output word_t mem_write_data,
	output logic  cmd_busy
);

	typedef enum logic [1:0] {
		seq_empty,
		seq_pending,
		seq_issued
	} seq_state_t;

	seq_state_t state;

	assign cmd_busy = (state != seq_empty);

	//////////////////////////////
	// command holding registers
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (cmd_valid && state == seq_empty) begin
			mem_address    <= cmd_address;
			mem_write_data <= cmd_data;
		end
	end

	//////////////////////////////
	// phase control
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= seq_empty;
			mem_enable <= 1'b0;
			mem_read   <= 1'b0;
			mem_write  <= 1'b0;
		end else begin
			mem_enable <= 1'b0;   // one-cycle pulse
			case (state)
				seq_empty: begin
					if (cmd_valid) begin
						mem_read  <= ~cmd_write;
						mem_write <= cmd_write;
						if (mem_ready) begin
							mem_enable <= 1'b1;
							state      <= seq_issued;
						end else begin
							state <= seq_pending;
						end
					end
				end
				seq_pending: begin
					if (mem_ready) begin
						mem_enable <= 1'b1;
						state      <= seq_issued;
					end
				end
				seq_issued: begin
					// ready is only trusted once the enable pulse is gone
					if (!mem_enable && mem_ready) begin
						state <= seq_empty;
					end
				end
				default: state <= seq_empty;
			endcase
		end
	end

endmodule

// ==== source/wait_state_memory.sv ====
module wait_state_memory
	import line_fetch_pkg::*;
(
	input  logic  clock,
	input  logic  reset,
	input  logic  mem_enable,
	input  logic  mem_read,
	input  logic  mem_write,
	input  addr_t mem_address,
	input  word_t mem_write_data,
	output logic  mem_ready,
	output logic  read_valid,
	output word_t read_data
);

	word_t mem_data [MEM_WORDS];

	mem_state_t state;
	logic [WAIT_COUNT_BITS-1:0] wait_count;
	word_index_t burst_index;

	// latched access
	logic op_read;
	logic [MEM_INDEX_BITS-1:0] op_index;
	word_t op_data;

	addr_t base_address;
	logic [MEM_INDEX_BITS-1:0] req_index;
	logic [MEM_INDEX_BITS-1:0] line_index;
	logic [MEM_INDEX_BITS-1:0] burst_addr;

	assign base_address = line_base(mem_address);
	assign req_index    = mem_address[BYTE_OFFSET_BITS +: MEM_INDEX_BITS];
	assign line_index   = base_address[BYTE_OFFSET_BITS +: MEM_INDEX_BITS];
	assign burst_addr   = op_index + MEM_INDEX_BITS'(burst_index);  // low bits of base are zero

	//////////////////////////////
	// access capture
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (state == mem_idle && mem_enable) begin
			op_read <= mem_read;
			op_data <= mem_write_data;
			if (mem_read) begin
				op_index <= line_index;
			end else begin
				op_index <= req_index;
			end
		end
	end

	//////////////////////////////
	// state machine and storage
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem_data[i] <= '0;
			end
			state       <= mem_idle;
			mem_ready   <= 1'b1;
			read_valid  <= 1'b0;
			read_data   <= '0;
			wait_count  <= '0;
			burst_index <= '0;
		end else begin
			read_valid <= 1'b0;
			case (state)
				mem_idle: begin
					if (mem_enable && (mem_read || mem_write)) begin
						mem_ready  <= 1'b0;
						wait_count <= '0;
						state      <= mem_wait;
					end
				end
				mem_wait: begin
					if (wait_count == WAIT_COUNT_BITS'(WAIT_STATES)) begin
						if (op_read) begin
							read_data   <= mem_data[op_index];  // first word at the line base
							read_valid  <= 1'b1;
							burst_index <= word_index_t'(1);
							state       <= mem_burst;
						end else begin
							mem_data[op_index] <= op_data;
							mem_ready          <= 1'b1;
							state              <= mem_idle;
						end
					end else begin
						wait_count <= wait_count + 1'b1;
					end
				end
				mem_burst: begin
					read_data   <= mem_data[burst_addr];
					read_valid  <= 1'b1;
					burst_index <= burst_index + 1'b1;
					if (burst_index == word_index_t'(LINE_WORDS - 1)) begin
						mem_ready <= 1'b1;   // rises with the last word
						state     <= mem_idle;
					end
				end
				default: begin
					mem_ready <= 1'b1;
					state     <= mem_idle;
				end
			endcase
		end
	end

endmodule

// ==== tb.f ====
source/line_fetch_pkg.sv
source/request_sequencer.sv
source/wait_state_memory.sv
source/line_assembler.sv
source/line_fetch_top.sv
dv/line_fetch_chk.sv
dv/tb_line_fetch.sv
